//--- Makefile
# Verilator flow for the four-phase CDC project.
# Any variable can be overridden, e.g. make sim LOG=run.log

VERILATOR ?= verilator
TOP       ?= cdc_4phase_tb
RTL_TOP   ?= cdc_4phase
FILELIST  ?= cdc_4phase.f
RTL_SRCS  ?= cdc_pkg.sv cdc_sync.sv cdc_4phase_src.sv cdc_4phase_dst.sv cdc_4phase.sv
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= Regression failed
VFLAGS    ?= --timing --assert --timescale 1ns/1ps

.PHONY: all lint build sim clean

all: sim

# Lint the design on its own, then together with the testbench.
lint:
	$(VERILATOR) --lint-only $(VFLAGS) $(RTL_SRCS) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

# The log decides the result; a crash or assertion stop also fails.
sim: build
	@./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; \
	cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "Simulation reported a failure, see $(LOG)"; \
	  exit 1; \
	fi; \
	if [ $$status -ne 0 ]; then \
	  echo "Simulator exited with status $$status, see $(LOG)"; \
	  exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- cdc_4phase.f
cdc_pkg.sv
cdc_sync.sv
cdc_4phase_src.sv
cdc_4phase_dst.sv
cdc_4phase.sv
cdc_4phase_assert.sv
cdc_4phase_tb.sv

//--- cdc_4phase.sv
`timescale 1ns/1ps
`default_nettype none

module cdc_4phase (
  input  logic                       src_clk_i,
  input  logic                       dst_clk_i,
  input  logic                       rst_i,
  input  logic [cdc_pkg::DATA_W-1:0] src_data_i,
  input  logic                       src_valid_i,
  output logic                       src_ready_o,
  output logic [cdc_pkg::DATA_W-1:0] dst_data_o,
  output logic                       dst_valid_o,
  input  logic                       dst_ready_i
);

  // Signals that cross between the clock domains.
  logic                       async_req;
  logic                       async_ack;
  logic [cdc_pkg::DATA_W-1:0] async_data;

  // Control levels after synchronization.
  logic                       req_sync;
  logic                       ack_sync;

  cdc_4phase_src u_src (
    .src_clk_i    (src_clk_i),
    .rst_i        (rst_i),
    .src_data_i   (src_data_i),
    .src_valid_i  (src_valid_i),
    .src_ready_o  (src_ready_o),
    .ack_sync_i   (ack_sync),
    .async_req_o  (async_req),
    .async_data_o (async_data)
  );

  // Request into the destination clock.
  cdc_sync u_req_sync (
    .dst_clk_i (dst_clk_i),
    .rst_i     (rst_i),
    .d_i       (async_req),
    .q_o       (req_sync)
  );

  // Acknowledge back into the source clock.
  cdc_sync u_ack_sync (
    .dst_clk_i (src_clk_i),
    .rst_i     (rst_i),
    .d_i       (async_ack),
    .q_o       (ack_sync)
  );

  cdc_4phase_dst u_dst (
    .dst_clk_i    (dst_clk_i),
    .rst_i        (rst_i),
    .req_sync_i   (req_sync),
    .async_data_i (async_data),
    .dst_ready_i  (dst_ready_i),
    .dst_data_o   (dst_data_o),
    .dst_valid_o  (dst_valid_o),
    .async_ack_o  (async_ack)
  );

endmodule

`default_nettype wire

//--- cdc_4phase_assert.sv
`timescale 1ns/1ps
`default_nettype none

module cdc_4phase_assert (
  input logic                       src_clk_i,
  input logic                       dst_clk_i,
  input logic                       rst_i,
  input logic [cdc_pkg::DATA_W-1:0] src_data_i,
  input logic                       src_valid_i,
  input logic                       src_ready_i,
  input logic [cdc_pkg::DATA_W-1:0] dst_data_i,
  input logic                       dst_valid_i,
  input logic                       dst_ready_i,
  input logic                       async_req_i,
  input logic                       async_ack_i,
  input logic [cdc_pkg::DATA_W-1:0] async_data_i
);

  // Crossing word must not move while the request is up.
  a_data_stable: assert property (@(posedge src_clk_i) disable iff (rst_i)
    async_req_i && $past(async_req_i) |-> $stable(async_data_i))
    else $error("async_data changed while async_req was high");

  // Phase 1 only starts once phase 4 is complete.
  a_req_rise: assert property (@(posedge src_clk_i) disable iff (rst_i)
    $rose(async_req_i) |-> !async_ack_i)
    else $error("async_req rose while async_ack was still high");

  a_ack_rise: assert property (@(posedge dst_clk_i) disable iff (rst_i)
    $rose(async_ack_i) |-> async_req_i)
    else $error("async_ack rose without a pending request");

  a_ack_fall: assert property (@(posedge dst_clk_i) disable iff (rst_i)
    $fell(async_ack_i) |-> !async_req_i)
    else $error("async_ack fell while async_req was high");

  // Valid/ready hold rules on both external ports.
  a_src_hold: assert property (@(posedge src_clk_i) disable iff (rst_i)
    src_valid_i && !src_ready_i |=> src_valid_i && $stable(src_data_i))
    else $error("source valid or data changed while stalled");

  a_dst_hold: assert property (@(posedge dst_clk_i) disable iff (rst_i)
    dst_valid_i && !dst_ready_i |=> dst_valid_i && $stable(dst_data_i))
    else $error("destination valid or data changed under back-pressure");

endmodule

bind cdc_4phase cdc_4phase_assert u_assert (
  .src_clk_i    (src_clk_i),
  .dst_clk_i    (dst_clk_i),
  .rst_i        (rst_i),
  .src_data_i   (src_data_i),
  .src_valid_i  (src_valid_i),
  .src_ready_i  (src_ready_o),
  .dst_data_i   (dst_data_o),
  .dst_valid_i  (dst_valid_o),
  .dst_ready_i  (dst_ready_i),
  .async_req_i  (async_req),
  .async_ack_i  (async_ack),
  .async_data_i (async_data)
);

`default_nettype wire

//--- cdc_4phase_dst.sv
`timescale 1ns/1ps
`default_nettype none

module cdc_4phase_dst (
  input  logic                       dst_clk_i,
  input  logic                       rst_i,
  input  logic                       req_sync_i,
  input  logic [cdc_pkg::DATA_W-1:0] async_data_i,
  input  logic                       dst_ready_i,
  output logic [cdc_pkg::DATA_W-1:0] dst_data_o,
  output logic                       dst_valid_o,
  output logic                       async_ack_o
);

  cdc_pkg::dst_state_e state_q;
  cdc_pkg::dst_state_e state_d;

  logic                       valid_q;
  logic                       ack_q;
  logic [cdc_pkg::DATA_W-1:0] data_q;
  logic                       capture;
  logic                       take;

  // First cycle with the request seen high.
  // The word on async_data_i has been stable for the synchronizer delay.
  assign capture = (state_q == cdc_pkg::DST_IDLE) & req_sync_i;

  // Consumer takes the offered word.
  assign take = valid_q & dst_ready_i;

  always_comb begin
    state_d = state_q;
    case (state_q)
      cdc_pkg::DST_IDLE: begin
        if (req_sync_i) begin
          state_d = cdc_pkg::DST_OFFER;
        end
      end
      cdc_pkg::DST_OFFER: begin
        // Low ready keeps the word here and withholds the acknowledge.
        if (take) begin
          state_d = cdc_pkg::DST_ACK;
        end
      end
      cdc_pkg::DST_ACK: begin
        if (!req_sync_i) begin
          state_d = cdc_pkg::DST_IDLE;
        end
      end
      default: begin
        state_d = cdc_pkg::DST_IDLE;
      end
    endcase
  end

  // Valid and acknowledge are registered decodes of the next state.
  always_ff @(posedge dst_clk_i) begin
    if (rst_i) begin
      state_q <= cdc_pkg::DST_IDLE;
      valid_q <= 1'b0;
      ack_q   <= 1'b0;
    end else begin
      state_q <= state_d;
      valid_q <= (state_d == cdc_pkg::DST_OFFER);
      ack_q   <= (state_d == cdc_pkg::DST_ACK);
    end
  end

  // Output word register.
  always_ff @(posedge dst_clk_i) begin
    if (capture) begin
      data_q <= async_data_i;
    end
  end

  assign dst_data_o  = data_q;
  assign dst_valid_o = valid_q;
  assign async_ack_o = ack_q;

endmodule

`default_nettype wire

//--- cdc_4phase_src.sv
`timescale 1ns/1ps
`default_nettype none

module cdc_4phase_src (
  input  logic                       src_clk_i,
  input  logic                       rst_i,
  input  logic [cdc_pkg::DATA_W-1:0] src_data_i,
  input  logic                       src_valid_i,
  output logic                       src_ready_o,
  input  logic                       ack_sync_i,
  output logic                       async_req_o,
  output logic [cdc_pkg::DATA_W-1:0] async_data_o
);

  cdc_pkg::src_state_e state_q;
  cdc_pkg::src_state_e state_d;

  logic                       ready_q;
  logic                       req_q;
  logic [cdc_pkg::DATA_W-1:0] data_q;
  logic                       accept;

  // A word is taken when valid meets ready.
  assign accept = src_valid_i & ready_q;

  always_comb begin
    state_d = state_q;
    case (state_q)
      cdc_pkg::SRC_IDLE: begin
        if (accept) begin
          state_d = cdc_pkg::SRC_REQ;
        end
      end
      cdc_pkg::SRC_REQ: begin
        // Phase 2 seen, drop the request.
        if (ack_sync_i) begin
          state_d = cdc_pkg::SRC_RELEASE;
        end
      end
      cdc_pkg::SRC_RELEASE: begin
        // Phase 4 seen, the round trip is complete.
        if (!ack_sync_i) begin
          state_d = cdc_pkg::SRC_IDLE;
        end
      end
      default: begin
        state_d = cdc_pkg::SRC_IDLE;
      end
    endcase
  end

  // Ready and request come from flops so the crossing sees clean levels.
  // Ready is low in the first cycle after reset and rises one edge later.
  always_ff @(posedge src_clk_i) begin
    if (rst_i) begin
      state_q <= cdc_pkg::SRC_IDLE;
      ready_q <= 1'b0;
      req_q   <= 1'b0;
    end else begin
      state_q <= state_d;
      ready_q <= (state_d == cdc_pkg::SRC_IDLE);
      req_q   <= (state_d == cdc_pkg::SRC_REQ);
    end
  end

  // Word register, loaded only on the accepting edge.
  // It holds while the request is pending.
  always_ff @(posedge src_clk_i) begin
    if (accept) begin
      data_q <= src_data_i;
    end
  end

  assign src_ready_o  = ready_q;
  assign async_req_o  = req_q;
  assign async_data_o = data_q;

endmodule

`default_nettype wire

//--- cdc_4phase_tb.sv
`timescale 1ns/1ps
`default_nettype none

module cdc_4phase_tb;

  localparam int NUM_WORDS      = 400;
  localparam int TIMEOUT_CYCLES = NUM_WORDS * 40;

  // Source clock starts high so its falling edges never meet a dst edge.
  logic                       src_clk_i = 1'b1;
  logic                       dst_clk_i = 1'b0;
  logic                       rst_i;
  logic [cdc_pkg::DATA_W-1:0] src_data_i;
  logic                       src_valid_i;
  logic                       src_ready_o;
  logic [cdc_pkg::DATA_W-1:0] dst_data_o;
  logic                       dst_valid_o;
  logic                       dst_ready_i;

  integer                     seed            = 32'h00c2_5d8d;
  logic [cdc_pkg::DATA_W-1:0] exp_queue[$];
  int                         sent_count      = 0;
  int                         recv_count      = 0;
  int                         error_count     = 0;
  int                         end_error_count = 0;
  int                         cycle_count     = 0;
  logic                       throttle_dst    = 1'b0;
  logic                       hold_pending    = 1'b0;
  logic [cdc_pkg::DATA_W-1:0] held_data       = '0;

  always #4 dst_clk_i = ~dst_clk_i;
  always #6.5 src_clk_i = ~src_clk_i;

  cdc_4phase UUT (
    .src_clk_i   (src_clk_i),
    .dst_clk_i   (dst_clk_i),
    .rst_i       (rst_i),
    .src_data_i  (src_data_i),
    .src_valid_i (src_valid_i),
    .src_ready_o (src_ready_o),
    .dst_data_o  (dst_data_o),
    .dst_valid_o (dst_valid_o),
    .dst_ready_i (dst_ready_i)
  );

  function automatic int random_below(input int limit);
    logic [31:0] rnd;
    rnd = $random(seed);
    return int'(rnd % limit);
  endfunction

  // Reference model.
  // Words leave in the order they were accepted, with their value unchanged.
  function automatic logic [cdc_pkg::DATA_W-1:0] expected_word();
    return exp_queue.pop_front();
  endfunction

  // Offers one word and holds it until the handshake edge.
  task automatic send_word(input logic [cdc_pkg::DATA_W-1:0] word);
    src_data_i  = word;
    src_valid_i = 1'b1;
    do begin
      @(posedge src_clk_i);
    end while (src_ready_o !== 1'b1);
    exp_queue.push_back(word);
    sent_count = sent_count + 1;
    @(negedge src_clk_i);
    src_valid_i = 1'b0;
  endtask

  task automatic finish_run(input bit stalled);
    int total;
    total = error_count + end_error_count + (stalled ? 1 : 0);
    $display("Errors: %0d (checks %0d, end of run %0d, timeout %0d), sent %0d, received %0d",
             total, error_count, end_error_count, stalled ? 1 : 0, sent_count, recv_count);
    if (total == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  endtask

  initial begin : run_source
    rst_i       = 1'b1;
    src_valid_i = 1'b0;
    src_data_i  = '0;
    repeat (8) @(negedge dst_clk_i);
    rst_i = 1'b0;
    @(negedge src_clk_i);
    for (int i = 0; i < NUM_WORDS; i++) begin
      // Second half runs against random back-pressure.
      if (i == NUM_WORDS / 2) begin
        throttle_dst = 1'b1;
      end
      // Gaps range from back to back up to longer than one round trip.
      repeat (random_below(20)) @(negedge src_clk_i);
      send_word($random(seed));
    end
    wait (recv_count == NUM_WORDS);
    // Let the last round trip close and then watch for stray words.
    wait (src_ready_o === 1'b1);
    repeat (20) @(posedge dst_clk_i);
    if (sent_count != NUM_WORDS || recv_count != NUM_WORDS) begin
      $display("FAILED at %0t: sent %0d and received %0d words, expected %0d each",
               $time, sent_count, recv_count, NUM_WORDS);
      end_error_count = end_error_count + 1;
    end
    if (exp_queue.size() != 0) begin
      $display("FAILED at %0t: %0d accepted words never arrived", $time, exp_queue.size());
      end_error_count = end_error_count + 1;
    end
    finish_run(1'b0);
  end

  // Destination consumer is always ready or throttled in random stretches.
  initial begin : drive_dst_ready
    int   stretch;
    logic level;
    dst_ready_i = 1'b0;
    stretch     = 0;
    level       = 1'b1;
    forever begin
      @(negedge dst_clk_i);
      if (!throttle_dst) begin
        dst_ready_i = 1'b1;
      end else begin
        if (stretch == 0) begin
          level   = ~level;
          stretch = level ? 1 + random_below(6) : 1 + random_below(16);
        end
        dst_ready_i = level;
        stretch     = stretch - 1;
      end
    end
  end

  always @(posedge dst_clk_i) begin : compare_output
    logic [cdc_pkg::DATA_W-1:0] expected;
    if (dst_valid_o === 1'b1 && sent_count == 0) begin
      $display("FAILED at %0t: dst_valid_o high before any word was accepted", $time);
      error_count = error_count + 1;
    end
    if (hold_pending && dst_valid_o !== 1'b1) begin
      $display("FAILED at %0t: dst_valid_o dropped under back-pressure", $time);
      error_count = error_count + 1;
    end
    if (hold_pending && dst_data_o !== held_data) begin
      $display("FAILED at %0t: dst_data_o moved from %08h to %08h under back-pressure",
               $time, held_data, dst_data_o);
      error_count = error_count + 1;
    end
    // The source cannot be ready while its word is still on offer.
    if (dst_valid_o === 1'b1 && src_ready_o === 1'b1) begin
      $display("FAILED at %0t: src_ready_o high while a word is still offered", $time);
      error_count = error_count + 1;
    end
    if (dst_valid_o === 1'b1 && dst_ready_i === 1'b1) begin
      if (exp_queue.size() == 0) begin
        $display("FAILED at %0t: extra word %08h delivered", $time, dst_data_o);
        error_count = error_count + 1;
      end else begin
        expected = expected_word();
        if (dst_data_o !== expected) begin
          $display("FAILED at %0t: word %0d expected %08h got %08h",
                   $time, recv_count, expected, dst_data_o);
          error_count = error_count + 1;
        end
      end
      recv_count = recv_count + 1;
    end
    hold_pending = (dst_valid_o === 1'b1) && (dst_ready_i !== 1'b1);
    held_data    = dst_data_o;
  end

  always @(posedge dst_clk_i) begin : watchdog
    cycle_count = cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d dst cycles: the transfer stalled with %0d of %0d words received",
               cycle_count, recv_count, NUM_WORDS);
      finish_run(1'b1);
    end
  end

endmodule

`default_nettype wire

//--- cdc_pkg.sv
`default_nettype none

package cdc_pkg;

  // Width of one transferred word.
  localparam int DATA_W = 32;

  // Flops in each level synchronizer.
  localparam int SYNC_STAGES = 2;

  // Source side of the four-phase handshake.
  // SRC_IDLE waits for a word on the valid/ready port.
  // SRC_REQ keeps the request high until the acknowledge is seen.
  // SRC_RELEASE keeps the request low until the acknowledge drops.
  typedef enum logic [1:0] {
    SRC_IDLE    = 2'd0,
    SRC_REQ     = 2'd1,
    SRC_RELEASE = 2'd2
  } src_state_e;

  // Destination side of the four-phase handshake.
  // DST_IDLE waits for the synchronized request.
  // DST_OFFER presents the captured word until it is taken.
  // DST_ACK keeps the acknowledge high until the request drops.
  typedef enum logic [1:0] {
    DST_IDLE  = 2'd0,
    DST_OFFER = 2'd1,
    DST_ACK   = 2'd2
  } dst_state_e;

endpackage

`default_nettype wire

//--- cdc_sync.sv
`timescale 1ns/1ps
`default_nettype none

module cdc_sync (
  input  logic dst_clk_i,
  input  logic rst_i,
  input  logic d_i,
  output logic q_o
);

  // Shift chain, bit 0 is the first flop after the crossing.
  logic [cdc_pkg::SYNC_STAGES-1:0] sync_q;

  always_ff @(posedge dst_clk_i) begin
    if (rst_i) begin
      sync_q <= '0;
    end else begin
      sync_q <= {sync_q[cdc_pkg::SYNC_STAGES-2:0], d_i};
    end
  end

  // Last stage is the settled level.
  assign q_o = sync_q[cdc_pkg::SYNC_STAGES-1];

endmodule

`default_nettype wire
